// ==== src/alu_exec.sv ====
`default_nettype none

module alu_exec
    import isa_pkg::*, pipe_pkg::*;
(
    input  id_ex_t          i_ex,
    input  fwd_sel_e        i_fwd_a,
    input  fwd_sel_e        i_fwd_b,
    input  logic [XLEN-1:0] i_mem_result,
    input  logic [XLEN-1:0] i_wb_result,
    output ex_mem_t         o_mem
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] result;

    function automatic logic [XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                                 input logic [XLEN-1:0] reg_val);
        logic [XLEN-1:0] val;
        case (sel)
            FWD_MEM: val = i_mem_result;
            FWD_WB:  val = i_wb_result;
            default: val = reg_val;
        endcase
        return val;
    endfunction

    always_comb
    begin
        op_a    = fwd_mux(i_fwd_a, i_ex.rs1_data);
        rs2_val = fwd_mux(i_fwd_b, i_ex.rs2_data);
        op_b    = i_ex.ctrl.alu_src ? i_ex.imm : rs2_val;

        case (i_ex.ctrl.alu_op)
            SUB:     result = op_a - op_b;
            AND:     result = op_a & op_b;
            OR:      result = op_a | op_b;
            XOR:     result = op_a ^ op_b;
            SLT:     result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            SLL:     result = op_a << op_b[4:0];
            SRL:     result = op_a >> op_b[4:0];
            default: result = op_a + op_b;
        endcase

        o_mem.ctrl       = i_ex.ctrl;
        o_mem.alu_result = result;
        o_mem.write_data = rs2_val;
        o_mem.rd         = i_ex.rd;
    end

endmodule

`default_nettype wire

// ==== src/core_top.sv ====
`default_nettype none

module core_top
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_imem_we,
    input  logic [IMEM_AW-1:0]    i_imem_addr,
    input  logic [XLEN-1:0]       i_imem_data,
    output logic                  o_wb_valid,
    output logic [REG_ADDR_W-1:0] o_wb_rd,
    output logic [XLEN-1:0]       o_wb_data,
    output logic                  o_st_valid,
    output logic [XLEN-1:0]       o_st_addr,
    output logic [XLEN-1:0]       o_st_data
);

    if_id_t   if_next, id_stage;
    id_ex_t   id_next, ex_stage;
    ex_mem_t  ex_next, mem_stage;
    mem_wb_t  mem_next, wb_stage;

    ctrl_t                 dec_ctrl;
    logic [XLEN-1:0]       dec_imm;
    logic [REG_ADDR_W-1:0] dec_rs1, dec_rs2, dec_rd;
    logic [XLEN-1:0]       rs1_data, rs2_data;
    logic [XLEN-1:0]       mem_rdata;
    logic [XLEN-1:0]       wb_data;
    fwd_sel_e              fwd_a, fwd_b;
    logic                  stall;

    fetch fetch_i (
        .clk(clk), .i_rst_n(i_rst_n), .i_stall(stall),
        .i_imem_we(i_imem_we), .i_imem_addr(i_imem_addr), .i_imem_data(i_imem_data),
        .o_if(if_next)
    );

    if_id if_id_i (.clk(clk), .i_rst_n(i_rst_n), .i_stall(stall),
                   .i_stage(if_next), .o_stage(id_stage));

    decoder decoder_i (
        .i_instr(id_stage.instr), .o_ctrl(dec_ctrl), .o_imm(dec_imm),
        .o_rs1(dec_rs1), .o_rs2(dec_rs2), .o_rd(dec_rd)
    );

    reg_file reg_file_i (
        .clk(clk), .i_rst_n(i_rst_n), .i_rs1(dec_rs1), .i_rs2(dec_rs2),
        .o_rs1_data(rs1_data), .o_rs2_data(rs2_data),
        .i_we(wb_stage.reg_write), .i_rd(wb_stage.rd), .i_wd(wb_data)
    );

    assign id_next = '{ctrl: dec_ctrl, rs1_data: rs1_data, rs2_data: rs2_data,
                       imm: dec_imm, rs1: dec_rs1, rs2: dec_rs2, rd: dec_rd};

    id_ex id_ex_i (.clk(clk), .i_rst_n(i_rst_n), .i_stall(stall),
                   .i_stage(id_next), .o_stage(ex_stage));

    hazard_unit hazard_unit_i (
        .i_id_rs1(dec_rs1), .i_id_rs2(dec_rs2), .i_ex(ex_stage), .i_mem(mem_stage),
        .i_wb(wb_stage), .o_fwd_a(fwd_a), .o_fwd_b(fwd_b), .o_stall(stall)
    );

    alu_exec alu_exec_i (
        .i_ex(ex_stage), .i_fwd_a(fwd_a), .i_fwd_b(fwd_b),
        .i_mem_result(mem_stage.alu_result), .i_wb_result(wb_data), .o_mem(ex_next)
    );

    ex_mem ex_mem_i (.clk(clk), .i_rst_n(i_rst_n), .i_stage(ex_next), .o_stage(mem_stage));

    data_mem data_mem_i (
        .clk(clk), .i_we(mem_stage.ctrl.mem_write),
        .i_addr(mem_stage.alu_result[DMEM_AW+1:2]), .i_wdata(mem_stage.write_data),
        .o_rdata(mem_rdata)
    );

    assign mem_next = '{reg_write: mem_stage.ctrl.reg_write, mem2reg: mem_stage.ctrl.mem2reg,
                        alu_result: mem_stage.alu_result, mem_data: mem_rdata,
                        rd: mem_stage.rd};

    mem_wb mem_wb_i (.clk(clk), .i_rst_n(i_rst_n), .i_stage(mem_next), .o_stage(wb_stage));

    // Writeback select
    assign wb_data = wb_stage.mem2reg ? wb_stage.mem_data : wb_stage.alu_result;

    assign o_wb_valid = wb_stage.reg_write;
    assign o_wb_rd    = wb_stage.rd;
    assign o_wb_data  = wb_data;

    assign o_st_valid = mem_stage.ctrl.mem_write;
    assign o_st_addr  = mem_stage.alu_result;
    assign o_st_data  = mem_stage.write_data;

endmodule

`default_nettype wire

// ==== src/data_mem.sv ====
`default_nettype none

module data_mem
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic               clk,
    input  logic               i_we,
    input  logic [DMEM_AW-1:0] i_addr,
    input  logic [XLEN-1:0]    i_wdata,
    output logic [XLEN-1:0]    o_rdata
);

    logic [XLEN-1:0] mem [DMEM_DEPTH];

    always_ff @(posedge clk)
    begin
        if (i_we)
        begin
            mem[i_addr] <= i_wdata;
        end
    end

    assign o_rdata = mem[i_addr];

endmodule

`default_nettype wire

// ==== src/decoder.sv ====
`default_nettype none

module decoder
    import isa_pkg::*, pipe_pkg::*;
(
    input  instr_u                i_instr,
    output ctrl_t                 o_ctrl,
    output logic [XLEN-1:0]       o_imm,
    output logic [REG_ADDR_W-1:0] o_rs1,
    output logic [REG_ADDR_W-1:0] o_rs2,
    output logic [REG_ADDR_W-1:0] o_rd
);

    function automatic alu_op_e map_alu(input logic [2:0] f3, input logic sub);
        alu_op_e op;
        case (f3)
            F3_ADD:  op = sub ? SUB : ADD;
            F3_SLL:  op = SLL;
            F3_SLT:  op = SLT;
            F3_XOR:  op = XOR;
            F3_SRL:  op = SRL;
            F3_OR:   op = OR;
            F3_AND:  op = AND;
            default: op = ADD;
        endcase
        return op;
    endfunction

    always_comb
    begin
        o_ctrl = '0;
        o_imm  = '0;
        o_rs1  = i_instr.r_fmt.rs1;
        o_rs2  = '0;
        o_rd   = i_instr.r_fmt.rd;

        case (i_instr.r_fmt.opcode)
            OP_REG:
            begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.alu_op    = map_alu(i_instr.r_fmt.funct3,
                                           i_instr.r_fmt.funct7 == F7_SUB);
                o_rs2            = i_instr.r_fmt.rs2;
            end
            OP_IMM:
            begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.alu_src   = 1'b1;
                o_ctrl.alu_op    = map_alu(i_instr.i_fmt.funct3, 1'b0);
                o_imm            = {{20{i_instr.i_fmt.imm[11]}}, i_instr.i_fmt.imm};
            end
            OP_LOAD:
            begin
                // Only lw; other widths decode as a nop
                if (i_instr.i_fmt.funct3 == F3_WORD)
                begin
                    o_ctrl.reg_write = 1'b1;
                    o_ctrl.mem2reg   = 1'b1;
                    o_ctrl.alu_src   = 1'b1;
                end
                o_imm = {{20{i_instr.i_fmt.imm[11]}}, i_instr.i_fmt.imm};
            end
            OP_STORE:
            begin
                if (i_instr.s_fmt.funct3 == F3_WORD)
                begin
                    o_ctrl.mem_write = 1'b1;
                    o_ctrl.alu_src   = 1'b1;
                end
                o_imm = {{20{i_instr.s_fmt.imm_hi[6]}}, i_instr.s_fmt.imm_hi,
                         i_instr.s_fmt.imm_lo};
                o_rs2 = i_instr.s_fmt.rs2;
                o_rd  = '0;
            end
            default:
            begin
                o_rs1 = '0;
                o_rd  = '0;
            end
        endcase

        // No x0 write ever leaves decode
        if (o_rd == '0)
        begin
            o_ctrl.reg_write = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== src/fetch.sv ====
`default_nettype none

module fetch
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_stall,
    input  logic               i_imem_we,
    input  logic [IMEM_AW-1:0] i_imem_addr,
    input  logic [XLEN-1:0]    i_imem_data,
    output if_id_t             o_if
);

    logic [XLEN-1:0]    imem [IMEM_DEPTH];
    // Word index, not byte address
    logic [IMEM_AW-1:0] pc;

    always_ff @(posedge clk)
    begin
        if (i_imem_we)
        begin
            imem[i_imem_addr] <= i_imem_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!i_rst_n)
        begin
            pc <= '0;
        end
        else if (!i_stall)
        begin
            pc <= pc + 1'b1;
        end
    end

    assign o_if.instr.raw = imem[pc];

endmodule

`default_nettype wire

// ==== src/hazard_unit.sv ====
`default_nettype none

module hazard_unit
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic [REG_ADDR_W-1:0] i_id_rs1,
    input  logic [REG_ADDR_W-1:0] i_id_rs2,
    input  id_ex_t                i_ex,
    input  ex_mem_t               i_mem,
    input  mem_wb_t               i_wb,
    output fwd_sel_e              o_fwd_a,
    output fwd_sel_e              o_fwd_b,
    output logic                  o_stall
);

    // reg_write implies rd != x0, so x0 sources never match
    function automatic fwd_sel_e pick(input logic [REG_ADDR_W-1:0] src);
        fwd_sel_e sel;
        if (i_mem.ctrl.reg_write && !i_mem.ctrl.mem2reg && i_mem.rd == src)
        begin
            sel = FWD_MEM;
        end
        else if (i_wb.reg_write && i_wb.rd == src)
        begin
            sel = FWD_WB;
        end
        else
        begin
            sel = FWD_NONE;
        end
        return sel;
    endfunction

    always_comb
    begin
        o_fwd_a = pick(i_ex.rs1);
        o_fwd_b = pick(i_ex.rs2);
        // Load in execute feeding the instruction in decode
        o_stall = i_ex.ctrl.mem2reg && i_ex.ctrl.reg_write &&
                  (i_ex.rd == i_id_rs1 || i_ex.rd == i_id_rs2);
    end

endmodule

`default_nettype wire

// ==== src/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef enum logic [6:0] {
        OP_REG   = 7'b0110011,
        OP_IMM   = 7'b0010011,
        OP_LOAD  = 7'b0000011,
        OP_STORE = 7'b0100011
    } opcode_e;

    // ALU funct3 codes
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // Word width for lw/sw
    localparam logic [2:0] F3_WORD = 3'b010;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    // addi x0, x0, 0
    localparam logic [XLEN-1:0] NOP_WORD = 32'h0000_0013;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        opcode_e               opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        opcode_e               opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        opcode_e               opcode;
    } s_fmt_t;

    // One instruction word, seen through each encoding format
    typedef union packed {
        r_fmt_t            r_fmt;
        i_fmt_t            i_fmt;
        s_fmt_t            s_fmt;
        logic [XLEN-1:0]   raw;
    } instr_u;

endpackage

`default_nettype wire

// ==== src/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

    localparam int IMEM_DEPTH = 64;
    localparam int DMEM_DEPTH = 64;
    localparam int IMEM_AW    = 6;
    localparam int DMEM_AW    = 6;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLL,
        SRL
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    // All-zero is a bubble
    typedef struct packed {
        logic    reg_write;
        logic    mem_write;
        logic    mem2reg;
        logic    alu_src;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        isa_pkg::instr_u instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t                          ctrl;
        logic [isa_pkg::XLEN-1:0]       rs1_data;
        logic [isa_pkg::XLEN-1:0]       rs2_data;
        logic [isa_pkg::XLEN-1:0]       imm;
        logic [isa_pkg::REG_ADDR_W-1:0] rs1;
        logic [isa_pkg::REG_ADDR_W-1:0] rs2;
        logic [isa_pkg::REG_ADDR_W-1:0] rd;
    } id_ex_t;

    typedef struct packed {
        ctrl_t                          ctrl;
        logic [isa_pkg::XLEN-1:0]       alu_result;
        logic [isa_pkg::XLEN-1:0]       write_data;
        logic [isa_pkg::REG_ADDR_W-1:0] rd;
    } ex_mem_t;

    typedef struct packed {
        logic                           reg_write;
        logic                           mem2reg;
        logic [isa_pkg::XLEN-1:0]       alu_result;
        logic [isa_pkg::XLEN-1:0]       mem_data;
        logic [isa_pkg::REG_ADDR_W-1:0] rd;
    } mem_wb_t;

endpackage

`default_nettype wire

// ==== src/pipe_regs.sv ====
`default_nettype none

module if_id
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic   clk,
    input  logic   i_rst_n,
    input  logic   i_stall,
    input  if_id_t i_stage,
    output if_id_t o_stage
);

    always_ff @(posedge clk)
    begin
        if (!i_rst_n)
        begin
            o_stage.instr.raw <= NOP_WORD;
        end
        else if (!i_stall)
        begin
            o_stage <= i_stage;
        end
    end

endmodule

module id_ex
    import pipe_pkg::*;
(
    input  logic   clk,
    input  logic   i_rst_n,
    input  logic   i_stall,
    input  id_ex_t i_stage,
    output id_ex_t o_stage
);

    // Payload always loads, only the control fields become a bubble
    always_ff @(posedge clk)
    begin
        o_stage <= i_stage;
        if (!i_rst_n || i_stall)
        begin
            o_stage.ctrl <= '0;
        end
    end

endmodule

module ex_mem
    import pipe_pkg::*;
(
    input  logic    clk,
    input  logic    i_rst_n,
    input  ex_mem_t i_stage,
    output ex_mem_t o_stage
);

    always_ff @(posedge clk)
    begin
        o_stage <= i_stage;
        if (!i_rst_n)
        begin
            o_stage.ctrl <= '0;
        end
    end

endmodule

module mem_wb
    import pipe_pkg::*;
(
    input  logic    clk,
    input  logic    i_rst_n,
    input  mem_wb_t i_stage,
    output mem_wb_t o_stage
);

    always_ff @(posedge clk)
    begin
        o_stage <= i_stage;
        if (!i_rst_n)
        begin
            o_stage.reg_write <= 1'b0;
            o_stage.mem2reg   <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
`default_nettype none

module reg_file
    import isa_pkg::*;
(
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic [REG_ADDR_W-1:0] i_rs1,
    input  logic [REG_ADDR_W-1:0] i_rs2,
    output logic [XLEN-1:0]       o_rs1_data,
    output logic [XLEN-1:0]       o_rs2_data,
    input  logic                  i_we,
    input  logic [REG_ADDR_W-1:0] i_rd,
    input  logic [XLEN-1:0]       i_wd
);

    logic [XLEN-1:0] regs [1:2**REG_ADDR_W-1];

    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] sel);
        logic [XLEN-1:0] val;
        if (sel == '0)
        begin
            val = '0;
        end
        else if (i_we && i_rd == sel)
        begin
            // Writeback in the same cycle wins
            val = i_wd;
        end
        else
        begin
            val = regs[sel];
        end
        return val;
    endfunction

    always_ff @(posedge clk)
    begin
        if (!i_rst_n)
        begin
            for (int i = 1; i < 2**REG_ADDR_W; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (i_we && i_rd != '0)
        begin
            regs[i_rd] <= i_wd;
        end
    end

    always_comb
    begin
        o_rs1_data = read_port(i_rs1);
        o_rs2_data = read_port(i_rs2);
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+tests
src/isa_pkg.sv
src/pipe_pkg.sv
src/pipe_regs.sv
src/fetch.sv
src/decoder.sv
src/reg_file.sv
src/hazard_unit.sv
src/alu_exec.sv
src/data_mem.sv
src/core_top.sv
tests/core_tb.sv

// ==== tests/ref_model.svh ====
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// 16-bit Fibonacci LFSR, taps 16 14 13 11
logic [15:0] lfsr_state = 16'd83;

function automatic logic [31:0] lfsr_bits(input int count);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < count; i++)
    begin
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        val = {val[30:0], fb};
    end
    return val;
endfunction

function automatic logic [XLEN-1:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input op_t op);
    return {f7, op.rs2, op.rs1, f3, op.rd, OP_REG};
endfunction

function automatic logic [XLEN-1:0] enc_i(input opcode_e opc, input logic [2:0] f3,
                                          input op_t op);
    return {op.imm, op.rs1, f3, op.rd, opc};
endfunction

function automatic logic [XLEN-1:0] enc_s(input op_t op);
    return {op.imm[11:5], op.rs2, op.rs1, F3_WORD, op.imm[4:0], OP_STORE};
endfunction

function automatic logic [XLEN-1:0] encode(input op_t op);
    logic [XLEN-1:0] word;
    case (op.kind)
        K_ADD:   word = enc_r(F7_BASE, F3_ADD, op);
        K_SUB:   word = enc_r(F7_SUB, F3_ADD, op);
        K_AND:   word = enc_r(F7_BASE, F3_AND, op);
        K_OR:    word = enc_r(F7_BASE, F3_OR, op);
        K_XOR:   word = enc_r(F7_BASE, F3_XOR, op);
        K_SLT:   word = enc_r(F7_BASE, F3_SLT, op);
        K_SLL:   word = enc_r(F7_BASE, F3_SLL, op);
        K_SRL:   word = enc_r(F7_BASE, F3_SRL, op);
        K_ADDI:  word = enc_i(OP_IMM, F3_ADD, op);
        K_ANDI:  word = enc_i(OP_IMM, F3_AND, op);
        K_ORI:   word = enc_i(OP_IMM, F3_OR, op);
        K_XORI:  word = enc_i(OP_IMM, F3_XOR, op);
        K_SLTI:  word = enc_i(OP_IMM, F3_SLT, op);
        K_LW:    word = enc_i(OP_LOAD, F3_WORD, op);
        default: word = enc_s(op);
    endcase
    return word;
endfunction

function automatic logic [XLEN-1:0] model_alu(input kind_e kind, input logic [XLEN-1:0] a,
                                              input logic [XLEN-1:0] b);
    logic [XLEN-1:0] r;
    case (kind)
        K_SUB:         r = a - b;
        K_AND, K_ANDI: r = a & b;
        K_OR, K_ORI:   r = a | b;
        K_XOR, K_XORI: r = a ^ b;
        K_SLT, K_SLTI: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        K_SLL:         r = a << b[4:0];
        K_SRL:         r = a >> b[4:0];
        default:       r = a + b;
    endcase
    return r;
endfunction

// Runs prog in order and queues the events the core must produce
function automatic void run_reference();
    logic [XLEN-1:0] regs [32];
    logic [XLEN-1:0] mem [DMEM_DEPTH];
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] res;
    op_t             op;
    wb_event_t       wb_ev;
    st_event_t       st_ev;
    foreach (regs[i])
        regs[i] = '0;
    foreach (mem[i])
        mem[i] = '0;
    foreach (prog[n])
    begin
        op   = prog[n];
        a    = regs[op.rs1];
        b    = regs[op.rs2];
        imm  = {{20{op.imm[11]}}, op.imm};
        addr = a + imm;
        if (op.kind == K_SW)
        begin
            mem[addr[DMEM_AW+1:2]] = b;
            st_ev.addr = addr;
            st_ev.data = b;
            exp_st_q.push_back(st_ev);
        end
        else
        begin
            if (op.kind == K_LW)
                res = mem[addr[DMEM_AW+1:2]];
            else if (op.kind inside {K_ADDI, K_ANDI, K_ORI, K_XORI, K_SLTI})
                res = model_alu(op.kind, a, imm);
            else
                res = model_alu(op.kind, a, b);
            if (op.rd != 5'd0)
            begin
                regs[op.rd] = res;
                wb_ev.rd    = op.rd;
                wb_ev.data  = res;
                exp_wb_q.push_back(wb_ev);
            end
        end
    end
endfunction

function automatic void emit(input kind_e kind, input logic [4:0] rd, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic [11:0] imm);
    op_t op;
    op.kind = kind;
    op.rd   = rd;
    op.rs1  = rs1;
    op.rs2  = rs2;
    op.imm  = imm;
    prog.push_back(op);
endfunction

// Registers drawn from x0..x7 so dependencies and load-use pairs are frequent
function automatic void build_random_program(input int count);
    logic [5:0]  stored [$];
    logic [31:0] pick;
    logic [5:0]  idx;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    kind_e       kind;
    prog.delete();
    for (int n = 0; n < count; n++)
    begin
        pick = lfsr_bits(4);
        kind = (pick[3:0] < 4'd15) ? kind_e'(pick[3:0]) : K_ADDI;
        if (n == 0 && (kind == K_SW || kind == K_LW))
            kind = K_ADDI;
        else if (kind == K_LW && stored.size() == 0)
            kind = K_SW;
        pick = lfsr_bits(3);
        rd   = {2'b00, pick[2:0]};
        pick = lfsr_bits(3);
        rs1  = {2'b00, pick[2:0]};
        pick = lfsr_bits(3);
        rs2  = {2'b00, pick[2:0]};
        case (kind)
            K_SW:
            begin
                pick = lfsr_bits(6);
                idx  = pick[5:0];
                stored.push_back(idx);
                emit(K_SW, 5'd0, 5'd0, rs2, {4'b0000, idx, 2'b00});
            end
            K_LW:
            begin
                pick = lfsr_bits(6);
                idx  = stored[pick % stored.size()];
                emit(K_LW, rd, 5'd0, 5'd0, {4'b0000, idx, 2'b00});
            end
            K_ADDI, K_ANDI, K_ORI, K_XORI, K_SLTI:
            begin
                pick = lfsr_bits(12);
                emit(kind, rd, rs1, 5'd0, pick[11:0]);
            end
            default:
                emit(kind, rd, rs1, rs2, 12'h000);
        endcase
    end
endfunction

`endif

// ==== tests/core_tb.sv ====
`default_nettype none

module core_tb
    import isa_pkg::*, pipe_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic [3:0] {
        K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT, K_SLL, K_SRL,
        K_ADDI, K_ANDI, K_ORI, K_XORI, K_SLTI, K_LW, K_SW
    } kind_e;

    typedef struct packed {
        kind_e       kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
    } op_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_event_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
    } st_event_t;

    logic                  clk = 1'b0;
    logic                  i_rst_n;
    logic                  i_imem_we;
    logic [IMEM_AW-1:0]    i_imem_addr;
    logic [XLEN-1:0]       i_imem_data;
    logic                  o_wb_valid;
    logic [REG_ADDR_W-1:0] o_wb_rd;
    logic [XLEN-1:0]       o_wb_data;
    logic                  o_st_valid;
    logic [XLEN-1:0]       o_st_addr;
    logic [XLEN-1:0]       o_st_data;

    op_t       prog [$];
    wb_event_t exp_wb_q [$];
    st_event_t exp_st_q [$];

    int   cycle_count   = 0;
    int   deadline      = 0;
    logic watch_on      = 1'b0;
    int   reset_edges   = 0;
    int   since_release = 0;

    `include "ref_model.svh"

    core_top core_top_i (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_imem_we(i_imem_we), .i_imem_addr(i_imem_addr), .i_imem_data(i_imem_data),
        .o_wb_valid(o_wb_valid), .o_wb_rd(o_wb_rd), .o_wb_data(o_wb_data),
        .o_st_valid(o_st_valid), .o_st_addr(o_st_addr), .o_st_data(o_st_data)
    );

    always #50 clk = ~clk;

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("[ERROR] time %0d ns: %s expected 0x%08h, actual 0x%08h",
                     $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic compare_wb();
        wb_event_t ev;
        if (exp_wb_q.size() == 0)
        begin
            $display("Writeback to x%0d at time %0d ns with no writeback expected",
                     o_wb_rd, $time);
            abort_run();
        end
        else
        begin
            ev = exp_wb_q.pop_front();
            check_value("o_wb_rd", 32'(ev.rd), 32'(o_wb_rd));
            check_value("o_wb_data", ev.data, o_wb_data);
        end
    endtask

    task automatic compare_st();
        st_event_t ev;
        if (exp_st_q.size() == 0)
        begin
            $display("Store to 0x%08h at time %0d ns with no store expected", o_st_addr, $time);
            abort_run();
        end
        else
        begin
            ev = exp_st_q.pop_front();
            check_value("o_st_addr", ev.addr, o_st_addr);
            check_value("o_st_data", ev.data, o_st_data);
        end
    endtask

    // Strobes must stay low in reset and for four cycles after release
    always @(posedge clk)
    begin
        if (!i_rst_n)
        begin
            if (reset_edges > 0)
            begin
                check_value("o_wb_valid", 32'd0, 32'(o_wb_valid));
                check_value("o_st_valid", 32'd0, 32'(o_st_valid));
            end
            reset_edges   = reset_edges + 1;
            since_release = 0;
        end
        else
        begin
            reset_edges   = 0;
            since_release = since_release + 1;
            if (since_release <= 4)
            begin
                check_value("o_wb_valid", 32'd0, 32'(o_wb_valid));
                check_value("o_st_valid", 32'd0, 32'(o_st_valid));
            end
            if (o_wb_valid === 1'b1)
                compare_wb();
            if (o_st_valid === 1'b1)
                compare_st();
        end
    end

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
    end

    // Checked on the falling edge after the compare process has popped
    always @(negedge clk)
    begin
        if (watch_on && cycle_count >= deadline && (exp_wb_q.size() + exp_st_q.size()) > 0)
        begin
            $display("Timeout: %0d writeback and %0d store events never arrived",
                     exp_wb_q.size(), exp_st_q.size());
            abort_run();
        end
    end

    // Load the program under reset, release, wait for every expected event
    task automatic run_program();
        @(negedge clk);
        i_rst_n = 1'b0;
        for (int a = 0; a < IMEM_DEPTH; a++)
        begin
            i_imem_we   = 1'b1;
            i_imem_addr = a[IMEM_AW-1:0];
            i_imem_data = (a < prog.size()) ? encode(prog[a]) : NOP_WORD;
            @(negedge clk);
        end
        i_imem_we = 1'b0;
        repeat (2) @(negedge clk);
        run_reference();
        deadline = cycle_count + prog.size() * 2 + 20;
        watch_on = 1'b1;
        i_rst_n  = 1'b1;
        while (exp_wb_q.size() != 0 || exp_st_q.size() != 0)
            @(negedge clk);
        watch_on = 1'b0;
        // Room for any stray strobe to show up
        repeat (8) @(negedge clk);
    endtask

    function automatic void emit_nops(input int count);
        repeat (count) emit(K_ADDI, 5'd0, 5'd0, 5'd0, 12'h000);
    endfunction

    function automatic void build_alu_program();
        prog.delete();
        emit(K_ADDI, 5'd1, 5'd0, 5'd0, 12'hffb);
        emit(K_ADDI, 5'd2, 5'd0, 5'd0, 12'h123);
        emit(K_ADDI, 5'd3, 5'd0, 5'd0, 12'd37);
        emit(K_ADDI, 5'd4, 5'd0, 5'd0, 12'h7ff);
        emit_nops(3);
        emit(K_ADD,  5'd5,  5'd1, 5'd2, 12'h000);
        emit(K_SUB,  5'd6,  5'd1, 5'd2, 12'h000);
        emit(K_SUB,  5'd7,  5'd2, 5'd1, 12'h000);
        emit(K_AND,  5'd8,  5'd1, 5'd2, 12'h000);
        emit(K_OR,   5'd9,  5'd1, 5'd2, 12'h000);
        emit(K_XOR,  5'd10, 5'd1, 5'd2, 12'h000);
        emit(K_SLT,  5'd11, 5'd1, 5'd2, 12'h000);
        emit(K_SLT,  5'd12, 5'd2, 5'd1, 12'h000);
        emit(K_SLL,  5'd13, 5'd2, 5'd3, 12'h000);
        emit(K_SRL,  5'd14, 5'd1, 5'd3, 12'h000);
        emit(K_SLL,  5'd15, 5'd1, 5'd4, 12'h000);
        emit(K_ADDI, 5'd16, 5'd1, 5'd0, 12'h064);
        emit(K_ANDI, 5'd17, 5'd2, 5'd0, 12'h0f0);
        emit(K_ORI,  5'd18, 5'd1, 5'd0, 12'h010);
        emit(K_XORI, 5'd19, 5'd2, 5'd0, 12'hfff);
        emit(K_SLTI, 5'd20, 5'd1, 5'd0, 12'hffc);
        emit(K_SLTI, 5'd21, 5'd2, 5'd0, 12'h005);
    endfunction

    function automatic void build_dependency_program();
        prog.delete();
        emit(K_ADDI, 5'd1, 5'd0, 5'd0, 12'd10);
        emit(K_ADDI, 5'd2, 5'd1, 5'd0, 12'd5);
        emit(K_ADD,  5'd3, 5'd2, 5'd1, 12'h000);
        emit(K_SUB,  5'd4, 5'd3, 5'd1, 12'h000);
        emit(K_XOR,  5'd5, 5'd2, 5'd4, 12'h000);
        emit_nops(1);
        emit(K_SLL,  5'd6, 5'd4, 5'd1, 12'h000);
        emit(K_OR,   5'd7, 5'd5, 5'd6, 12'h000);
        emit(K_ADD,  5'd7, 5'd7, 5'd7, 12'h000);
        // x7 pending in both later stages so the younger value must win
        emit(K_ADDI, 5'd7, 5'd7, 5'd0, 12'h001);
        emit(K_SRL,  5'd8, 5'd7, 5'd1, 12'h000);
    endfunction

    function automatic void build_load_use_program();
        prog.delete();
        emit(K_ADDI, 5'd1, 5'd0, 5'd0, 12'h040);
        emit(K_ADDI, 5'd2, 5'd0, 5'd0, 12'hfb3);
        emit(K_SW,   5'd0, 5'd1, 5'd2, 12'h004);
        emit(K_LW,   5'd3, 5'd1, 5'd0, 12'h004);
        emit(K_ADD,  5'd4, 5'd3, 5'd3, 12'h000);
        emit(K_SW,   5'd0, 5'd1, 5'd4, 12'h008);
        emit(K_LW,   5'd5, 5'd1, 5'd0, 12'h008);
        emit(K_SW,   5'd0, 5'd1, 5'd5, 12'h00c);
        emit(K_LW,   5'd6, 5'd1, 5'd0, 12'h00c);
        emit(K_ADDI, 5'd7, 5'd6, 5'd0, 12'h001);
    endfunction

    function automatic void build_x0_program();
        prog.delete();
        emit(K_ADDI, 5'd1, 5'd0, 5'd0, 12'd9);
        emit(K_ADDI, 5'd0, 5'd0, 5'd0, 12'd55);
        emit(K_ADD,  5'd0, 5'd1, 5'd1, 12'h000);
        emit(K_ADD,  5'd2, 5'd0, 5'd1, 12'h000);
        emit(K_OR,   5'd3, 5'd0, 5'd0, 12'h000);
        emit(K_SW,   5'd0, 5'd0, 5'd0, 12'h010);
        emit(K_LW,   5'd0, 5'd0, 5'd0, 12'h010);
        emit(K_LW,   5'd4, 5'd0, 5'd0, 12'h010);
        emit(K_ADDI, 5'd5, 5'd0, 5'd0, 12'h000);
    endfunction

    initial
    begin
        i_rst_n     = 1'b0;
        i_imem_we   = 1'b0;
        i_imem_addr = '0;
        i_imem_data = '0;
        build_alu_program();
        run_program();
        build_dependency_program();
        run_program();
        build_load_use_program();
        run_program();
        build_x0_program();
        run_program();
        build_random_program(40);
        run_program();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
